// File: mips_pkg.sv
//######################################################################
// MIPS instruction set definitions shared by the pipeline stages.
// Holds the word types, the kept primary opcodes and function codes,
// the R-type field layout and the reset PC. Import inside a module
// body where the names are needed.
//######################################################################
package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // primary opcodes, anything else decodes as a no-op
   typedef enum logic [5:0] {
      op_special = 6'h00,
      op_j       = 6'h02,
      op_beq     = 6'h04,
      op_bne     = 6'h05,
      op_addi    = 6'h08,
      op_addiu   = 6'h09,
      op_slti    = 6'h0a,
      op_andi    = 6'h0c,
      op_ori     = 6'h0d,
      op_xori    = 6'h0e,
      op_lui     = 6'h0f,
      op_lw      = 6'h23,
      op_sw      = 6'h2b
   } opcode_e;

   // funct field of op_special
   typedef enum logic [5:0] {
      fn_sll     = 6'h00,
      fn_srl     = 6'h02,
      fn_sra     = 6'h03,
      fn_syscall = 6'h0c,
      fn_add     = 6'h20,
      fn_addu    = 6'h21,
      fn_sub     = 6'h22,
      fn_subu    = 6'h23,
      fn_and     = 6'h24,
      fn_or      = 6'h25,
      fn_xor     = 6'h26,
      fn_nor     = 6'h27,
      fn_slt     = 6'h2a,
      fn_sltu    = 6'h2b
   } funct_e;

   // R-type layout, immediate is {rd, shamt, funct}, target is everything below opcode
   typedef struct packed {
      logic [5:0] opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } inst_t;

   localparam word_t text_start = 32'h0040_0000;

endpackage

// File: core_pkg.sv
//######################################################################
// Pipeline definitions for the five-stage core.
// ALU operations, branch kinds, forwarding selects, the decoded
// control word and the structs carried by the stage registers.
// Builds on the word types of the ISA package.
//######################################################################
package core_pkg;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_slt,
      alu_sltu,
      alu_sll,
      alu_srl,
      alu_sra,
      alu_lui
   } alu_op_e;

   typedef enum logic [1:0] {
      br_none,
      br_beq,
      br_bne,
      br_j
   } branch_e;

   // source of an EX operand, youngest producer first
   typedef enum logic [1:0] {
      fwd_none,
      fwd_mem,
      fwd_wb
   } fwd_sel_e;

   typedef struct packed {
      logic    reg_we;
      logic    mem_read;
      logic    mem_write;
      alu_op_e alu_op;
      logic    use_imm;
      branch_e branch;
      logic    is_syscall;
   } ctrl_t;

   localparam ctrl_t ctrl_nop = '0;

   typedef struct packed {
      logic            valid;
      mips_pkg::word_t pc;
      mips_pkg::inst_t inst;
   } if_id_t;

   typedef struct packed {
      logic               valid;
      ctrl_t              ctrl;
      mips_pkg::word_t    pc;
      mips_pkg::word_t    rs_val;
      mips_pkg::word_t    rt_val;
      mips_pkg::word_t    imm;
      mips_pkg::reg_idx_t rs;
      mips_pkg::reg_idx_t rt;
      mips_pkg::reg_idx_t dest;
      logic [4:0]         shamt;
      logic [25:0]        target;
   } id_ex_t;

   typedef struct packed {
      logic               valid;
      logic               reg_we;
      logic               mem_read;
      logic               mem_write;
      logic               is_syscall;
      mips_pkg::reg_idx_t dest;
      mips_pkg::word_t    result;
      mips_pkg::word_t    store_val;
   } ex_mem_t;

   typedef struct packed {
      logic               valid;
      logic               reg_we;
      logic               is_syscall;
      mips_pkg::reg_idx_t dest;
      mips_pkg::word_t    wb_data;
   } mem_wb_t;

endpackage

// File: regfile.sv
//######################################################################
// 32 x 32 general purpose register file.
// Two combinational read ports and one write port. A read of the
// register being written returns the new value in the same cycle.
//######################################################################
`timescale 1ns/1ps

module regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs,
   input  mips_pkg::reg_idx_t rt,
   input  logic               we,
   input  mips_pkg::reg_idx_t wr_idx,
   input  mips_pkg::word_t    wr_data,
   output mips_pkg::word_t    rs_val,
   output mips_pkg::word_t    rt_val
);
   import mips_pkg::*;

   word_t regs [32];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wr_idx != '0) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // $zero reads as zero, then write-through, then the array
   assign rs_val = (rs == '0) ? '0 : (we && wr_idx == rs) ? wr_data : regs[rs];
   assign rt_val = (rt == '0) ? '0 : (we && wr_idx == rt) ? wr_data : regs[rt];

endmodule

// File: mips_alu.sv
//######################################################################
// Integer ALU for the execute stage.
// Purely combinational. Shifts act on operand b by shamt, and lui
// moves the low half of b into the upper half of the result.
//######################################################################
`timescale 1ns/1ps

module mips_alu (
   input  core_pkg::alu_op_e op,
   input  mips_pkg::word_t   a,
   input  mips_pkg::word_t   b,
   input  logic [4:0]        shamt,
   output mips_pkg::word_t   result
);
   import core_pkg::*;

   always_comb begin
      case (op)
         alu_add:  result = a + b;
         alu_sub:  result = a - b;
         alu_and:  result = a & b;
         alu_or:   result = a | b;
         alu_xor:  result = a ^ b;
         alu_nor:  result = ~(a | b);
         // compares give 0 or 1
         alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
         alu_sltu: result = {31'b0, a < b};
         alu_sll:  result = b << shamt;
         alu_srl:  result = b >> shamt;
         alu_sra:  result = $signed(b) >>> shamt;
         alu_lui:  result = {b[15:0], 16'h0000};
         default:  result = '0;
      endcase
   end

endmodule

// File: fetch_unit.sv
//######################################################################
// Fetch stage of the core.
// Keeps the program counter and the IF/ID register. The PC goes out
// as a byte address and the instruction comes back in the same cycle.
//######################################################################
`timescale 1ns/1ps

module fetch_unit (
   input  logic              clk,
   input  logic              rst_b,
   input  logic              stall,
   input  logic              fetch_stop,
   input  logic              redirect,
   input  mips_pkg::word_t   redirect_pc,
   input  mips_pkg::word_t   inst,
   output mips_pkg::word_t   inst_addr,
   output core_pkg::if_id_t  if_id
);
   import mips_pkg::*;

   word_t pc;

   assign inst_addr = pc;

   // redirect wins over stall, stall wins over fetch_stop
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc    <= text_start;
         if_id <= '0;
      end else if (redirect) begin
         pc          <= redirect_pc;
         if_id.valid <= 1'b0;
      end else if (!stall) begin
         if (fetch_stop) begin
            // pc frozen, only bubbles toward decode
            if_id.valid <= 1'b0;
         end else begin
            pc          <= pc + 32'd4;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.inst  <= inst;
         end
      end
   end

endmodule

// File: decode_stage.sv
//######################################################################
// Decode stage of the core.
// Turns the IF/ID instruction into a control word, extends the
// immediate, reads the register file and loads the ID/EX register.
// Also raises the sticky fetch stop once a SYSCALL has gone through.
//######################################################################
`timescale 1ns/1ps

module decode_stage (
   input  logic                clk,
   input  logic                rst_b,
   input  core_pkg::if_id_t    if_id,
   input  logic                stall,
   input  logic                redirect,
   input  core_pkg::mem_wb_t   mem_wb,
   output core_pkg::id_ex_t    id_ex,
   output mips_pkg::reg_idx_t  id_rs,
   output mips_pkg::reg_idx_t  id_rt,
   output logic                id_uses_rt,
   output logic                fetch_stop
);
   import mips_pkg::*;
   import core_pkg::*;

   inst_t  inst;
   ctrl_t  ctrl;
   logic   id_live;
   logic   stop_q;
   logic   rt_dest;
   logic   zero_ext;
   logic   uses_rs;
   logic   uses_rt;
   logic   sys_in_id;
   word_t  rs_val;
   word_t  rt_val;
   word_t  imm;
   id_ex_t id_ex_d;

   assign inst    = if_id.inst;
   // nothing behind a SYSCALL is decoded
   assign id_live = if_id.valid & ~stop_q;

   always_comb begin
      ctrl     = ctrl_nop;
      rt_dest  = 1'b1;
      zero_ext = 1'b0;
      uses_rs  = 1'b1;
      uses_rt  = 1'b0;
      case (inst.opcode)
         op_special: begin
            rt_dest     = 1'b0;
            uses_rt     = 1'b1;
            ctrl.reg_we = 1'b1;
            case (inst.funct)
               fn_add, fn_addu: ctrl.alu_op = alu_add;
               fn_sub, fn_subu: ctrl.alu_op = alu_sub;
               fn_and:          ctrl.alu_op = alu_and;
               fn_or:           ctrl.alu_op = alu_or;
               fn_xor:          ctrl.alu_op = alu_xor;
               fn_nor:          ctrl.alu_op = alu_nor;
               fn_slt:          ctrl.alu_op = alu_slt;
               fn_sltu:         ctrl.alu_op = alu_sltu;
               fn_sll:          ctrl.alu_op = alu_sll;
               fn_srl:          ctrl.alu_op = alu_srl;
               fn_sra:          ctrl.alu_op = alu_sra;
               fn_syscall: begin
                  ctrl.reg_we     = 1'b0;
                  ctrl.is_syscall = 1'b1;
                  uses_rs         = 1'b0;
                  uses_rt         = 1'b0;
               end
               default: begin
                  ctrl.reg_we = 1'b0;
                  uses_rs     = 1'b0;
                  uses_rt     = 1'b0;
               end
            endcase
         end
         op_addi, op_addiu: ctrl = '{1'b1, 1'b0, 1'b0, alu_add, 1'b1, br_none, 1'b0};
         op_slti:           ctrl = '{1'b1, 1'b0, 1'b0, alu_slt, 1'b1, br_none, 1'b0};
         op_lui:            ctrl = '{1'b1, 1'b0, 1'b0, alu_lui, 1'b1, br_none, 1'b0};
         op_lw:             ctrl = '{1'b1, 1'b1, 1'b0, alu_add, 1'b1, br_none, 1'b0};
         op_andi, op_ori, op_xori: begin
            zero_ext = 1'b1;
            ctrl     = '{1'b1, 1'b0, 1'b0, alu_and, 1'b1, br_none, 1'b0};
            if (inst.opcode == op_ori) begin
               ctrl.alu_op = alu_or;
            end else if (inst.opcode == op_xori) begin
               ctrl.alu_op = alu_xor;
            end
         end
         op_sw: begin
            uses_rt = 1'b1;
            ctrl    = '{1'b0, 1'b0, 1'b1, alu_add, 1'b1, br_none, 1'b0};
         end
         op_beq, op_bne: begin
            uses_rt     = 1'b1;
            ctrl.alu_op = alu_sub;
            ctrl.branch = (inst.opcode == op_beq) ? br_beq : br_bne;
         end
         op_j:    ctrl.branch = br_j;
         default: uses_rs = 1'b0;
      endcase
      // shifts, lui and j carry no rs operand
      if (ctrl.alu_op inside {alu_sll, alu_srl, alu_sra, alu_lui} || ctrl.branch == br_j) begin
         uses_rs = 1'b0;
      end
   end

   assign imm = zero_ext ? {16'h0000, inst.rd, inst.shamt, inst.funct} :
                           {{16{inst.rd[4]}}, inst.rd, inst.shamt, inst.funct};

   // register numbers are zeroed when unused so the hazard unit sees no match
   assign id_rs      = (id_live & uses_rs) ? inst.rs : '0;
   assign id_rt      = (id_live & uses_rt) ? inst.rt : '0;
   assign id_uses_rt = id_live & uses_rt;

   // a squashed SYSCALL must not stop fetch
   assign sys_in_id  = id_live & ctrl.is_syscall & ~redirect;
   assign fetch_stop = stop_q | sys_in_id;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         stop_q <= 1'b0;
      end else if (sys_in_id && !stall) begin
         stop_q <= 1'b1;
      end
   end

   regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs      (inst.rs),
      .rt      (inst.rt),
      .we      (mem_wb.valid & mem_wb.reg_we),
      .wr_idx  (mem_wb.dest),
      .wr_data (mem_wb.wb_data),
      .rs_val  (rs_val),
      .rt_val  (rt_val)
   );

   always_comb begin
      id_ex_d        = '0;
      id_ex_d.valid  = 1'b1;
      id_ex_d.ctrl   = ctrl;
      id_ex_d.pc     = if_id.pc;
      id_ex_d.rs_val = rs_val;
      id_ex_d.rt_val = rt_val;
      id_ex_d.imm    = imm;
      id_ex_d.rs     = id_rs;
      id_ex_d.rt     = id_rt;
      id_ex_d.dest   = ctrl.reg_we ? (rt_dest ? inst.rt : inst.rd) : '0;
      id_ex_d.shamt  = inst.shamt;
      id_ex_d.target = {inst.rs, inst.rt, inst.rd, inst.shamt, inst.funct};
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         id_ex <= '0;
      end else if (stall || redirect || !id_live) begin
         // bubble into EX
         id_ex <= '0;
      end else begin
         id_ex <= id_ex_d;
      end
   end

endmodule

// File: hazard_unit.sv
//######################################################################
// Hazard detection for the pipeline.
// Holds IF and ID for one cycle when ID needs a load result still in
// EX, and picks the forwarding source for each EX operand.
//######################################################################
`timescale 1ns/1ps

module hazard_unit (
   input  mips_pkg::reg_idx_t  id_rs,
   input  mips_pkg::reg_idx_t  id_rt,
   input  logic                id_uses_rt,
   input  core_pkg::id_ex_t    id_ex,
   input  core_pkg::ex_mem_t   ex_mem,
   input  core_pkg::mem_wb_t   mem_wb,
   output logic                stall,
   output core_pkg::fwd_sel_e  fwd_rs,
   output core_pkg::fwd_sel_e  fwd_rt
);
   import mips_pkg::*;
   import core_pkg::*;

   logic load_in_ex;

   // MEM holds the younger producer and is checked first
   function automatic fwd_sel_e pick_src(reg_idx_t src);
      fwd_sel_e sel;
      sel = fwd_none;
      if (src != '0) begin
         if (ex_mem.valid && ex_mem.reg_we && ex_mem.dest == src) begin
            sel = fwd_mem;
         end else if (mem_wb.valid && mem_wb.reg_we && mem_wb.dest == src) begin
            sel = fwd_wb;
         end
      end
      return sel;
   endfunction

   assign load_in_ex = id_ex.valid & id_ex.ctrl.mem_read & (id_ex.dest != '0);

   // id_rs is zero when ID does not read rs
   assign stall = load_in_ex &
                  ((id_ex.dest == id_rs) | (id_uses_rt & (id_ex.dest == id_rt)));

   // selects follow EX/MEM and MEM/WB as well as the EX source numbers
   always_comb begin
      fwd_rs = pick_src(id_ex.rs);
      fwd_rt = pick_src(id_ex.rt);
   end

endmodule

// File: execute_stage.sv
//######################################################################
// Execute stage of the core.
// Forwards operands, runs the ALU, resolves BEQ, BNE and J and loads
// the EX/MEM register. A taken branch or jump redirects fetch at once.
//######################################################################
`timescale 1ns/1ps

module execute_stage (
   input  logic                clk,
   input  logic                rst_b,
   input  core_pkg::id_ex_t    id_ex,
   input  core_pkg::fwd_sel_e  fwd_rs,
   input  core_pkg::fwd_sel_e  fwd_rt,
   input  mips_pkg::word_t     wb_data,
   output core_pkg::ex_mem_t   ex_mem,
   output logic                redirect,
   output mips_pkg::word_t     redirect_pc
);
   import mips_pkg::*;
   import core_pkg::*;

   word_t rs_fwd;
   word_t rt_fwd;
   word_t alu_b;
   word_t alu_result;
   word_t pc_plus4;
   logic  taken;

   always_comb begin
      case (fwd_rs)
         fwd_mem: rs_fwd = ex_mem.result;
         fwd_wb:  rs_fwd = wb_data;
         default: rs_fwd = id_ex.rs_val;
      endcase
      case (fwd_rt)
         fwd_mem: rt_fwd = ex_mem.result;
         fwd_wb:  rt_fwd = wb_data;
         default: rt_fwd = id_ex.rt_val;
      endcase
   end

   assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : rt_fwd;

   mips_alu u_alu (
      .op     (id_ex.ctrl.alu_op),
      .a      (rs_fwd),
      .b      (alu_b),
      .shamt  (id_ex.shamt),
      .result (alu_result)
   );

   // no delay slot, both targets are relative to pc+4
   assign pc_plus4 = id_ex.pc + 32'd4;

   always_comb begin
      case (id_ex.ctrl.branch)
         br_beq:  taken = (rs_fwd == rt_fwd);
         br_bne:  taken = (rs_fwd != rt_fwd);
         br_j:    taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign redirect    = id_ex.valid & taken;
   assign redirect_pc = (id_ex.ctrl.branch == br_j) ?
                        {pc_plus4[31:28], id_ex.target, 2'b00} :
                        pc_plus4 + {id_ex.imm[29:0], 2'b00};

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_mem <= '0;
      end else begin
         ex_mem.valid      <= id_ex.valid;
         ex_mem.reg_we     <= id_ex.ctrl.reg_we;
         ex_mem.mem_read   <= id_ex.ctrl.mem_read;
         ex_mem.mem_write  <= id_ex.ctrl.mem_write;
         ex_mem.is_syscall <= id_ex.ctrl.is_syscall;
         ex_mem.dest       <= id_ex.dest;
         ex_mem.result     <= alu_result;
         // store data comes from rt after forwarding
         ex_mem.store_val  <= rt_fwd;
      end
   end

endmodule

// File: mips_core.sv
//######################################################################
// Top level of the five-stage MIPS integer pipeline.
// Connects fetch, decode, hazard and execute, drives the data memory
// from EX/MEM and keeps the MEM/WB register and the halt flag.
// Both memories answer combinationally, stores land at the next edge.
//######################################################################
`timescale 1ns/1ps

module mips_core (
   input  logic            clk,
   input  logic            rst_b,
   output mips_pkg::word_t inst_addr,
   input  mips_pkg::word_t inst,
   output mips_pkg::word_t mem_addr,
   input  mips_pkg::word_t mem_data_out,
   output mips_pkg::word_t mem_data_in,
   output logic            mem_write_en,
   output logic            halted
);
   import mips_pkg::*;
   import core_pkg::*;

   if_id_t   if_id;
   id_ex_t   id_ex;
   ex_mem_t  ex_mem;
   mem_wb_t  mem_wb;
   logic     stall;
   logic     redirect;
   word_t    redirect_pc;
   fwd_sel_e fwd_rs;
   fwd_sel_e fwd_rt;
   reg_idx_t id_rs;
   reg_idx_t id_rt;
   logic     id_uses_rt;
   logic     fetch_stop;

   fetch_unit u_fetch (
      .clk         (clk),
      .rst_b       (rst_b),
      .stall       (stall),
      .fetch_stop  (fetch_stop),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .inst        (inst),
      .inst_addr   (inst_addr),
      .if_id       (if_id)
   );

   decode_stage u_decode (
      .clk        (clk),
      .rst_b      (rst_b),
      .if_id      (if_id),
      .stall      (stall),
      .redirect   (redirect),
      .mem_wb     (mem_wb),
      .id_ex      (id_ex),
      .id_rs      (id_rs),
      .id_rt      (id_rt),
      .id_uses_rt (id_uses_rt),
      .fetch_stop (fetch_stop)
   );

   hazard_unit u_hazard (
      .id_rs      (id_rs),
      .id_rt      (id_rt),
      .id_uses_rt (id_uses_rt),
      .id_ex      (id_ex),
      .ex_mem     (ex_mem),
      .mem_wb     (mem_wb),
      .stall      (stall),
      .fwd_rs     (fwd_rs),
      .fwd_rt     (fwd_rt)
   );

   execute_stage u_execute (
      .clk         (clk),
      .rst_b       (rst_b),
      .id_ex       (id_ex),
      .fwd_rs      (fwd_rs),
      .fwd_rt      (fwd_rt),
      .wb_data     (mem_wb.wb_data),
      .ex_mem      (ex_mem),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   // data memory side, word accesses only
   assign mem_addr     = ex_mem.result;
   assign mem_data_in  = ex_mem.store_val;
   assign mem_write_en = ex_mem.valid & ex_mem.mem_write;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         mem_wb <= '0;
      end else begin
         mem_wb.valid      <= ex_mem.valid;
         mem_wb.reg_we     <= ex_mem.reg_we;
         mem_wb.is_syscall <= ex_mem.is_syscall;
         mem_wb.dest       <= ex_mem.dest;
         mem_wb.wb_data    <= ex_mem.mem_read ? mem_data_out : ex_mem.result;
      end
   end

   // set as the SYSCALL leaves WB, cleared only by reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (mem_wb.valid && mem_wb.is_syscall) begin
         halted <= 1'b1;
      end
   end

endmodule

// File: mips_core_props.sv
//######################################################################
// Concurrent checks on the pipeline, bound into the core top level.
// Covers the halt behavior, the squash after a redirect and the
// length of a load-use stall.
//######################################################################
`timescale 1ns/1ps

module mips_core_props (
   input logic clk,
   input logic rst_b,
   input logic mem_write_en,
   input logic halted,
   input logic redirect,
   input logic if_id_valid,
   input logic stall
);

   // nothing reaches memory once the core has stopped
   a_no_store_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> !mem_write_en)
      else $error("store issued while halted");

   // halt is sticky until reset
   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted)
      else $error("halted dropped without reset");

   // the instruction behind a taken branch or jump is squashed
   a_redirect_squash: assert property (@(posedge clk) disable iff (!rst_b)
      redirect |=> !if_id_valid)
      else $error("if_id still valid after redirect");

   // a load-use hold is exactly one bubble
   a_stall_single: assert property (@(posedge clk) disable iff (!rst_b)
      stall |=> !stall)
      else $error("stall held for two cycles");

endmodule

bind mips_core mips_core_props u_props (
   .clk          (clk),
   .rst_b        (rst_b),
   .mem_write_en (mem_write_en),
   .halted       (halted),
   .redirect     (redirect),
   .if_id_valid  (if_id.valid),
   .stall        (stall)
);

// File: tb_mips_core.sv
//######################################################################
// Testbench for the five-stage MIPS core.
// Loads program, data and expected stores from the trace file, models
// the instruction and data memories, checks every store in order and
// waits for the halt after SYSCALL.
//######################################################################
`timescale 1ns/1ps

module tb_mips_core;
   import mips_pkg::*;

   logic        clk;
   logic        rst_b;
   word_t       inst_addr;
   word_t       inst;
   word_t       mem_addr;
   word_t       mem_data_out;
   word_t       mem_data_in;
   logic        mem_write_en;
   logic        halted;

   // 256 instruction words from text_start and 1024 data words from 0
   word_t       imem [256];
   word_t       dmem [1024];
   word_t       inst_idx;
   word_t       exp_addr [$];
   word_t       exp_data [$];
   int          store_count;
   logic [31:0] lfsr_state;
   word_t       stop_pc;
   logic        stop_pc_known;

   mips_core uut (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_out (mem_data_out),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // combinational instruction memory that returns a nop outside the loaded range
   assign inst_idx = (inst_addr - text_start) >> 2;
   assign inst     = (inst_idx < 32'd256) ? imem[inst_idx[7:0]] : '0;

   // data memory reads combinationally and writes at the rising edge
   assign mem_data_out = dmem[mem_addr[11:2]];

   always @(posedge clk) begin
      if (mem_write_en) begin
         dmem[mem_addr[11:2]] <= mem_data_in;
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t expected);
      if (got !== expected) begin
         abort_run($sformatf("FAIL time=%0t %s got=%h expected=%h",
                             $time, name, got, expected));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic expected);
      if (got !== expected) begin
         abort_run($sformatf("FAIL time=%0t %s got=%b expected=%b",
                             $time, name, got, expected));
      end
   endtask

   // Galois form with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one LFSR step per bit taken and the low bit comes first
   task automatic take_bits(input int n, output int value);
      value = 0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = value | (int'(lfsr_state[0]) << k);
      end
   endtask

   // I is a program word, D initial data and S an expected store
   task automatic load_trace();
      int    fd;
      int    n;
      string line;
      string rest;
      byte   kind;
      word_t a;
      word_t v;
      word_t idx;
      fd = $fopen("mips_core_trace.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open the trace file mips_core_trace.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         // blank lines and # comments are skipped
         if (n > 1 && line[0] != "#") begin
            kind = line[0];
            rest = line.substr(1, line.len() - 1);
            if ($sscanf(rest, "%h %h", a, v) != 2) begin
               abort_run({"trace line cannot be parsed: ", line});
            end
            case (kind)
               "I": begin
                  idx = (a - text_start) >> 2;
                  if (idx >= 32'd256) begin
                     abort_run({"trace instruction outside memory: ", line});
                  end
                  imem[idx[7:0]] = v;
                  // fetch freezes on the word behind the SYSCALL
                  if (!stop_pc_known && v[31:26] == op_special && v[5:0] == fn_syscall) begin
                     stop_pc       = a + 32'd4;
                     stop_pc_known = 1'b1;
                  end
               end
               "D": dmem[a[11:2]] <= v;
               "S": begin
                  exp_addr.push_back(a);
                  exp_data.push_back(v);
               end
               default: abort_run({"unknown trace record: ", line});
            endcase
         end
      end
      $fclose(fd);
   endtask

   // every store seen in MEM must match the next S record
   always @(negedge clk) begin
      if (rst_b && mem_write_en) begin
         if (store_count >= exp_addr.size()) begin
            abort_run($sformatf("unexpected store of %h to address %h at time %0t",
                                mem_data_in, mem_addr, $time));
         end else begin
            check_word("mem_addr", mem_addr, exp_addr[store_count]);
            check_word("mem_data_in", mem_data_in, exp_data[store_count]);
            store_count++;
         end
      end
   end

   initial begin
      int idle;
      int cycles;
      rst_b         = 1'b0;
      store_count   = 0;
      lfsr_state    = 32'h2ab8;
      stop_pc       = '0;
      stop_pc_known = 1'b0;
      // fill pattern follows the byte address
      for (int i = 0; i < 1024; i++) begin
         dmem[i] <= word_t'(i << 2) ^ 32'h5a5a_c3c3;
      end
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0;
      end
      load_trace();
      if (!stop_pc_known) begin
         abort_run("the trace holds no SYSCALL, so the program cannot halt");
      end
      take_bits(3, idle);

      // reset for 16 cycles plus 0 to 7 idle ones
      repeat (16 + idle) begin
         @(negedge clk);
         check_word("inst_addr", inst_addr, text_start);
         check_bit("mem_write_en", mem_write_en, 1'b0);
         check_bit("halted", halted, 1'b0);
      end
      rst_b = 1'b1;
      #1;
      check_word("inst_addr", inst_addr, text_start);
      check_bit("mem_write_en", mem_write_en, 1'b0);
      check_bit("halted", halted, 1'b0);

      // run the program until SYSCALL retires
      cycles = 0;
      while (!halted && cycles < 200) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         abort_run("timeout, halted did not rise within 200 cycles");
      end

      // core stays frozen and quiet after the halt
      repeat (20) begin
         @(negedge clk);
         check_bit("mem_write_en", mem_write_en, 1'b0);
         check_word("inst_addr", inst_addr, stop_pc);
         check_bit("halted", halted, 1'b1);
      end

      if (store_count != exp_addr.size()) begin
         abort_run($sformatf("saw %0d stores but the trace expects %0d",
                             store_count, exp_addr.size()));
      end else begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

// File: mips_core.f
mips_pkg.sv
core_pkg.sv
regfile.sv
mips_alu.sv
fetch_unit.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
mips_core.sv
mips_core_props.sv
tb_mips_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mips_core
FILELIST  = mips_core.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mips_core_trace.txt
# columns: kind address value, all hex
# I = program word at byte address, D = initial data word, S = expected store in order
D 00000100 11111111
D 00000104 00000022
# ALU and forwarding at distance 1, 2 and 3
I 00400000 20010007
I 00400004 2002fff0
I 00400008 00221820
I 0040000c ac030200
I 00400010 00222022
I 00400014 00642826
I 00400018 00a43027
I 0040001c ac060204
I 00400020 0041382a
I 00400024 0022402b
I 00400028 00014900
I 0040002c 00025083
I 00400030 00025f02
I 00400034 00e86020
I 00400038 01896025
I 0040003c 014b6820
I 00400040 ac0c0208
I 00400044 ac0d020c
# immediates
I 00400048 3c0e1234
I 0040004c 35ce8765
I 00400050 304fff00
I 00400054 39ef00ff
I 00400058 2850fff1
I 0040005c 26100010
I 00400060 ac0e0210
I 00400064 ac0f0214
I 00400068 ac100218
# load-use on rs and on store data
I 0040006c 8c110100
I 00400070 02219020
I 00400074 8c130104
I 00400078 ac13021c
I 0040007c ac120220
# beq taken, bne not taken, bne taken, beq not taken, j
I 00400080 10210002
I 00400084 ac0102f0
I 00400088 ac0102f4
I 0040008c 14210002
I 00400090 ac070224
I 00400094 14220002
I 00400098 ac0102f8
I 0040009c ac0102fc
I 004000a0 10220001
I 004000a4 ac080228
I 004000a8 0810002d
I 004000ac ac0102f0
I 004000b0 ac0102f4
I 004000b4 ac0d022c
I 004000b8 0000000c
I 004000bc ac0102f8
S 00000200 fffffff7
S 00000204 00000008
S 00000208 00000072
S 0000020c 0000000b
S 00000210 12348765
S 00000214 0000ffff
S 00000218 00000011
S 0000021c 00000022
S 00000220 11111118
S 00000224 00000001
S 00000228 00000001
S 0000022c 0000000b
